// File: logic/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int PC_LSB     = 2;
    localparam int REG_IDX_W  = 5;
    localparam int FUNCT3_W   = 3;
    localparam int ALU_CTRL_W = 5;
    localparam int RES_SRC_W  = 2;

    // opcode bits 6..2, bits 1..0 must be 11
    localparam logic [4:0] OPG_LOAD     = 5'b00000;
    localparam logic [4:0] OPG_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPG_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPG_AUIPC    = 5'b00101;
    localparam logic [4:0] OPG_STORE    = 5'b01000;
    localparam logic [4:0] OPG_OP       = 5'b01100;
    localparam logic [4:0] OPG_LUI      = 5'b01101;
    localparam logic [4:0] OPG_BRANCH   = 5'b11000;
    localparam logic [4:0] OPG_JALR     = 5'b11001;
    localparam logic [4:0] OPG_JAL      = 5'b11011;
    localparam logic [4:0] OPG_SYSTEM   = 5'b11100;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // low four bits of the ALU control
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_XOR  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_AND  = 4'd4;
    localparam logic [3:0] ALU_SHL  = 4'd5;
    localparam logic [3:0] ALU_SHR  = 4'd6;
    localparam logic [3:0] CMP_EQ   = 4'd8;
    localparam logic [3:0] CMP_NEQ  = 4'd9;
    localparam logic [3:0] CMP_LTS  = 4'd10;
    localparam logic [3:0] CMP_NLTS = 4'd11;
    localparam logic [3:0] CMP_LTU  = 4'd12;
    localparam logic [3:0] CMP_NLTU = 4'd13;

    localparam logic [RES_SRC_W-1:0] RES_ALU   = 2'd0;
    localparam logic [RES_SRC_W-1:0] RES_MEM   = 2'd1;
    localparam logic [RES_SRC_W-1:0] RES_PC_P4 = 2'd2;

    localparam logic OP1_REG = 1'b0;
    localparam logic OP1_PC  = 1'b1;
    localparam logic OP2_REG = 1'b0;
    localparam logic OP2_IMM = 1'b1;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [FUNCT3_W-1:0]  funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]          imm;
        logic [REG_IDX_W-1:0] rs1;
        logic [FUNCT3_W-1:0]  funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_view_t;

    // shared by stores and branches
    typedef struct packed {
        logic [6:0]           imm_hi;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [FUNCT3_W-1:0]  funct3;
        logic [4:0]           imm_lo;
        logic [6:0]           opcode;
    } sb_view_t;

    typedef struct packed {
        logic [19:0]          imm;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } uj_view_t;

    typedef union packed {
        logic [XLEN-1:0] raw;
        r_view_t         r_view;
        i_view_t         i_view;
        sb_view_t        sb_view;
        uj_view_t        uj_view;
    } instr_u;

endpackage

// File: logic/fetch_hold.sv
`timescale 1ns/1ps

module fetch_hold import rv_decode_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  logic [XLEN-1:0]        i_data,
    input  logic [XLEN-1:PC_LSB]   i_pc,
    input  logic [XLEN-1:PC_LSB]   i_pc_p4,
    output instr_u                 o_instr,
    output logic [XLEN-1:PC_LSB]   o_pc,
    output logic [XLEN-1:PC_LSB]   o_pc_p4
);

    logic              r_stall;
    logic              r_flush;
    logic [XLEN-1:0]   r_held;
    logic [XLEN-1:0]   w_word;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_stall <= 1'b0;
            r_flush <= 1'b0;
        end
        else
        begin
            r_stall <= i_stall;
            r_flush <= i_flush;
        end
    end

    // keep the presented word while no stall is being replayed
    always_ff @(posedge i_clk)
    begin
        if (!r_stall)
            r_held <= w_word;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_flush)
        begin
            o_pc    <= '0;
            o_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            o_pc    <= i_pc;
            o_pc_p4 <= i_pc_p4;
        end
    end

    always_comb
    begin
        if (i_rst || r_flush)
            w_word = '0;
        else if (r_stall)
            w_word = r_held;
        else
            w_word = i_data;
    end

    assign o_instr.raw = w_word;

endmodule

// File: logic/instr_classify.sv
`timescale 1ns/1ps

module instr_classify import rv_decode_pkg::*;
(
    input  instr_u                  i_instr,
    output logic                    o_load,
    output logic                    o_store,
    output logic                    o_op_imm,
    output logic                    o_op_reg,
    output logic                    o_branch,
    output logic                    o_jal,
    output logic                    o_jalr,
    output logic                    o_lui,
    output logic                    o_auipc,
    output logic [ALU_CTRL_W-1:0]   o_alu_ctrl,
    output logic                    o_inv_instr
);

    logic [4:0]           w_grp;
    logic                 w_full;
    logic [FUNCT3_W-1:0]  w_f3;
    logic                 w_f7_base;
    logic                 w_f7_alt;

    logic g_load, g_misc_mem, g_op_imm, g_auipc, g_store;
    logic g_op, g_lui, g_branch, g_jalr, g_jal;

    logic i_addi, i_slli, i_slti, i_sltiu, i_xori, i_srli, i_srai, i_ori, i_andi;
    logic i_add, i_sub, i_sll, i_slt, i_sltu, i_xor, i_srl, i_sra, i_or, i_and;
    logic i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu;
    logic i_load, i_store, i_fence, i_none;

    assign w_grp     = i_instr.r_view.opcode[6:2];
    assign w_full    = (i_instr.r_view.opcode[1:0] == 2'b11);
    assign w_f3      = i_instr.r_view.funct3;
    assign w_f7_base = (i_instr.r_view.funct7 == F7_BASE);
    assign w_f7_alt  = (i_instr.r_view.funct7 == F7_ALT);

    assign g_load     = w_full && (w_grp == OPG_LOAD);
    assign g_misc_mem = w_full && (w_grp == OPG_MISC_MEM);
    assign g_op_imm   = w_full && (w_grp == OPG_OP_IMM);
    assign g_auipc    = w_full && (w_grp == OPG_AUIPC);
    assign g_store    = w_full && (w_grp == OPG_STORE);
    assign g_op       = w_full && (w_grp == OPG_OP);
    assign g_lui      = w_full && (w_grp == OPG_LUI);
    assign g_branch   = w_full && (w_grp == OPG_BRANCH);
    assign g_jalr     = w_full && (w_grp == OPG_JALR);
    assign g_jal      = w_full && (w_grp == OPG_JAL);

    // lb lh lw lbu lhu
    assign i_load  = g_load && (w_f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    assign i_store = g_store && (w_f3 inside {3'b000, 3'b001, 3'b010});
    // fence and fence.i
    assign i_fence = g_misc_mem && (w_f3 inside {3'b000, 3'b001});
    assign i_none  = (i_instr.raw == '0);

    assign i_addi  = g_op_imm && (w_f3 == 3'b000);
    assign i_slli  = g_op_imm && (w_f3 == 3'b001) && w_f7_base;
    assign i_slti  = g_op_imm && (w_f3 == 3'b010);
    assign i_sltiu = g_op_imm && (w_f3 == 3'b011);
    assign i_xori  = g_op_imm && (w_f3 == 3'b100);
    assign i_srli  = g_op_imm && (w_f3 == 3'b101) && w_f7_base;
    assign i_srai  = g_op_imm && (w_f3 == 3'b101) && w_f7_alt;
    assign i_ori   = g_op_imm && (w_f3 == 3'b110);
    assign i_andi  = g_op_imm && (w_f3 == 3'b111);

    assign i_add  = g_op && (w_f3 == 3'b000) && w_f7_base;
    assign i_sub  = g_op && (w_f3 == 3'b000) && w_f7_alt;
    assign i_sll  = g_op && (w_f3 == 3'b001) && w_f7_base;
    assign i_slt  = g_op && (w_f3 == 3'b010) && w_f7_base;
    assign i_sltu = g_op && (w_f3 == 3'b011) && w_f7_base;
    assign i_xor  = g_op && (w_f3 == 3'b100) && w_f7_base;
    assign i_srl  = g_op && (w_f3 == 3'b101) && w_f7_base;
    assign i_sra  = g_op && (w_f3 == 3'b101) && w_f7_alt;
    assign i_or   = g_op && (w_f3 == 3'b110) && w_f7_base;
    assign i_and  = g_op && (w_f3 == 3'b111) && w_f7_base;

    assign i_beq  = g_branch && (w_f3 == 3'b000);
    assign i_bne  = g_branch && (w_f3 == 3'b001);
    assign i_blt  = g_branch && (w_f3 == 3'b100);
    assign i_bge  = g_branch && (w_f3 == 3'b101);
    assign i_bltu = g_branch && (w_f3 == 3'b110);
    assign i_bgeu = g_branch && (w_f3 == 3'b111);

    assign o_load   = i_load;
    assign o_store  = i_store;
    assign o_op_imm = i_addi | i_slli | i_slti | i_sltiu | i_xori
                    | i_srli | i_srai | i_ori | i_andi;
    assign o_op_reg = i_add | i_sub | i_sll | i_slt | i_sltu
                    | i_xor | i_srl | i_sra | i_or | i_and;
    assign o_branch = i_beq | i_bne | i_blt | i_bge | i_bltu | i_bgeu;
    assign o_jal    = g_jal;
    assign o_jalr   = g_jalr && (w_f3 == 3'b000);
    assign o_lui    = g_lui;
    assign o_auipc  = g_auipc;

    // system group never matches, so ecall and ebreak end up here
    assign o_inv_instr = !(i_none | o_load | o_store | o_op_imm | o_op_reg | o_branch
                         | o_jal | o_jalr | o_lui | o_auipc | i_fence);

    assign o_alu_ctrl[4] = i_srai | i_sra;

    always_comb
    begin
        case (1'b1)
            i_beq:                         o_alu_ctrl[3:0] = CMP_EQ;
            (i_slti | i_slt | i_blt):      o_alu_ctrl[3:0] = CMP_LTS;
            (i_sltiu | i_sltu | i_bltu):   o_alu_ctrl[3:0] = CMP_LTU;
            i_bne:                         o_alu_ctrl[3:0] = CMP_NEQ;
            i_bge:                         o_alu_ctrl[3:0] = CMP_NLTS;
            i_bgeu:                        o_alu_ctrl[3:0] = CMP_NLTU;
            i_sub:                         o_alu_ctrl[3:0] = ALU_SUB;
            (i_xori | i_xor):              o_alu_ctrl[3:0] = ALU_XOR;
            (i_ori | i_or):                o_alu_ctrl[3:0] = ALU_OR;
            (i_andi | i_and):              o_alu_ctrl[3:0] = ALU_AND;
            (i_slli | i_sll):              o_alu_ctrl[3:0] = ALU_SHL;
            (i_srli | i_srl | i_srai | i_sra):
                                           o_alu_ctrl[3:0] = ALU_SHR;
            default:                       o_alu_ctrl[3:0] = ALU_ADD;
        endcase
    end

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_decode_pkg::*;
(
    input  instr_u            i_instr,
    input  logic              i_load,
    input  logic              i_store,
    input  logic              i_op_imm,
    input  logic              i_branch,
    input  logic              i_jal,
    input  logic              i_jalr,
    input  logic              i_lui,
    input  logic              i_auipc,
    output logic [XLEN-1:0]   o_imm
);

    logic [19:0] w_uj;
    logic [11:0] w_i;
    logic [6:0]  w_hi;
    logic [4:0]  w_lo;

    assign w_uj = i_instr.uj_view.imm;
    assign w_i  = i_instr.i_view.imm;
    assign w_hi = i_instr.sb_view.imm_hi;
    assign w_lo = i_instr.sb_view.imm_lo;

    always_comb
    begin
        case (1'b1)
            i_jal:
                o_imm = {{12{w_uj[19]}}, w_uj[7:0], w_uj[8], w_uj[18:9], 1'b0};
            (i_lui | i_auipc):
                o_imm = {w_uj, 12'b0};
            (i_jalr | i_load | i_op_imm):
                o_imm = {{20{w_i[11]}}, w_i};
            // bit 0 of the low field is imm[11] for branches
            i_branch:
                o_imm = {{20{w_hi[6]}}, w_lo[0], w_hi[5:0], w_lo[4:1], 1'b0};
            i_store:
                o_imm = {{20{w_hi[6]}}, w_hi, w_lo};
            default:
                o_imm = '0;
        endcase
    end

endmodule

// File: logic/operand_ctrl.sv
`timescale 1ns/1ps

module operand_ctrl import rv_decode_pkg::*;
(
    input  instr_u                  i_instr,
    input  logic                    i_load,
    input  logic                    i_store,
    input  logic                    i_op_imm,
    input  logic                    i_op_reg,
    input  logic                    i_branch,
    input  logic                    i_jal,
    input  logic                    i_jalr,
    input  logic                    i_lui,
    input  logic                    i_auipc,
    output logic [REG_IDX_W-1:0]    o_rs1,
    output logic [REG_IDX_W-1:0]    o_rs2,
    output logic [REG_IDX_W-1:0]    o_rd,
    output logic [FUNCT3_W-1:0]     o_funct3,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [RES_SRC_W-1:0]    o_res_src,
    output logic                    o_jump,
    output logic                    o_branch,
    output logic                    o_pc_sel,
    output logic                    o_alu_op1_sel,
    output logic                    o_alu_op2_sel
);

    // lui adds its immediate to x0
    assign o_rs1    = i_lui ? '0 : i_instr.r_view.rs1;
    assign o_rs2    = i_instr.r_view.rs2;
    assign o_rd     = i_instr.r_view.rd;
    assign o_funct3 = i_instr.r_view.funct3;

    assign o_reg_write = i_load | i_op_imm | i_op_reg | i_lui | i_auipc | i_jal | i_jalr;
    assign o_mem_read  = i_load;
    assign o_mem_write = i_store;
    assign o_jump      = i_jal | i_jalr;
    assign o_branch    = i_branch;
    assign o_pc_sel    = i_jalr;

    assign o_alu_op1_sel = (i_auipc | i_jal) ? OP1_PC : OP1_REG;
    assign o_alu_op2_sel = (i_auipc | i_jal | i_jalr | i_lui | i_op_imm | i_load | i_store)
                         ? OP2_IMM : OP2_REG;

    always_comb
    begin
        if (i_load)
            o_res_src = RES_MEM;
        else if (i_jal || i_jalr)
            o_res_src = RES_PC_P4;
        else
            o_res_src = RES_ALU;
    end

endmodule

// File: logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_decode_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic [XLEN-1:0]         i_data,
    input  logic [XLEN-1:PC_LSB]    i_pc,
    input  logic [XLEN-1:PC_LSB]    i_pc_p4,
    output logic [REG_IDX_W-1:0]    o_rs1,
    output logic [REG_IDX_W-1:0]    o_rs2,
    output logic [REG_IDX_W-1:0]    o_rd,
    output logic [XLEN-1:PC_LSB]    o_pc,
    output logic [XLEN-1:PC_LSB]    o_pc_p4,
    output logic [XLEN-1:0]         o_imm,
    output logic                    o_reg_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic [RES_SRC_W-1:0]    o_res_src,
    output logic                    o_pc_sel,
    output logic                    o_jump,
    output logic                    o_branch,
    output logic                    o_alu_op1_sel,
    output logic                    o_alu_op2_sel,
    output logic [FUNCT3_W-1:0]     o_funct3,
    output logic [ALU_CTRL_W-1:0]   o_alu_ctrl,
    output logic                    o_inv_instr
);

    instr_u w_instr;
    logic   w_load, w_store, w_op_imm, w_op_reg, w_branch;
    logic   w_jal, w_jalr, w_lui, w_auipc;

    fetch_hold u_fetch_hold (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_data  (i_data),
        .i_pc    (i_pc),
        .i_pc_p4 (i_pc_p4),
        .o_instr (w_instr),
        .o_pc    (o_pc),
        .o_pc_p4 (o_pc_p4)
    );

    instr_classify u_classify (
        .i_instr     (w_instr),
        .o_load      (w_load),
        .o_store     (w_store),
        .o_op_imm    (w_op_imm),
        .o_op_reg    (w_op_reg),
        .o_branch    (w_branch),
        .o_jal       (w_jal),
        .o_jalr      (w_jalr),
        .o_lui       (w_lui),
        .o_auipc     (w_auipc),
        .o_alu_ctrl  (o_alu_ctrl),
        .o_inv_instr (o_inv_instr)
    );

    imm_gen u_imm_gen (
        .i_instr  (w_instr),
        .i_load   (w_load),
        .i_store  (w_store),
        .i_op_imm (w_op_imm),
        .i_branch (w_branch),
        .i_jal    (w_jal),
        .i_jalr   (w_jalr),
        .i_lui    (w_lui),
        .i_auipc  (w_auipc),
        .o_imm    (o_imm)
    );

    operand_ctrl u_operand_ctrl (
        .i_instr       (w_instr),
        .i_load        (w_load),
        .i_store       (w_store),
        .i_op_imm      (w_op_imm),
        .i_op_reg      (w_op_reg),
        .i_branch      (w_branch),
        .i_jal         (w_jal),
        .i_jalr        (w_jalr),
        .i_lui         (w_lui),
        .i_auipc       (w_auipc),
        .o_rs1         (o_rs1),
        .o_rs2         (o_rs2),
        .o_rd          (o_rd),
        .o_funct3      (o_funct3),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_res_src     (o_res_src),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel)
    );

endmodule

// File: bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
    logic                  inv;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  jump;
    logic                  branch;
    logic                  pc_sel;
    logic                  op1_sel;
    logic                  op2_sel;
    logic [RES_SRC_W-1:0]  res_src;
    logic [ALU_CTRL_W-1:0] alu;
    logic [REG_IDX_W-1:0]  rs1;
    logic [REG_IDX_W-1:0]  rs2;
    logic [REG_IDX_W-1:0]  rd;
    logic [FUNCT3_W-1:0]   funct3;
    logic [XLEN-1:0]       imm;
    logic                  imm_chk;
} decode_exp_t;

// alu code of a register or immediate operation by funct3
function automatic logic [ALU_CTRL_W-1:0] alu_of(input logic [FUNCT3_W-1:0] f3,
                                                 input logic alt);
    case (f3)
        3'd0: return {1'b0, alt ? ALU_SUB : ALU_ADD};
        3'd1: return {1'b0, ALU_SHL};
        3'd2: return {1'b0, CMP_LTS};
        3'd3: return {1'b0, CMP_LTU};
        3'd4: return {1'b0, ALU_XOR};
        3'd5: return {alt, ALU_SHR};
        3'd6: return {1'b0, ALU_OR};
        default: return {1'b0, ALU_AND};
    endcase
endfunction

function automatic logic [ALU_CTRL_W-1:0] cmp_of(input logic [FUNCT3_W-1:0] f3);
    case (f3)
        3'd0: return {1'b0, CMP_EQ};
        3'd1: return {1'b0, CMP_NEQ};
        3'd4: return {1'b0, CMP_LTS};
        3'd5: return {1'b0, CMP_NLTS};
        3'd6: return {1'b0, CMP_LTU};
        default: return {1'b0, CMP_NLTU};
    endcase
endfunction

function automatic decode_exp_t decode_expect(input logic [XLEN-1:0] w);
    decode_exp_t         e;
    logic [FUNCT3_W-1:0] f3;
    logic [6:0]          f7;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_j;
    e      = '0;
    f3     = w[14:12];
    f7     = w[31:25];
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u  = {w[31:12], 12'b0};
    imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e.inv      = 1'b1;
    e.rs1      = w[19:15];
    e.rs2      = w[24:20];
    e.rd       = w[11:7];
    e.funct3   = f3;
    e.res_src  = RES_ALU;
    e.alu      = {1'b0, ALU_ADD};
    e.op1_sel  = OP1_REG;
    e.op2_sel  = OP2_REG;
    if (w == '0)
        e.inv = 1'b0;
    else if (w[1:0] == 2'b11)
    begin
        case (w[6:2])
            OPG_LOAD:
            begin
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5})
                begin
                    e.inv       = 1'b0;
                    e.reg_write = 1'b1;
                    e.mem_read  = 1'b1;
                    e.res_src   = RES_MEM;
                    e.op2_sel   = OP2_IMM;
                    e.imm       = imm_i;
                    e.imm_chk   = 1'b1;
                end
            end
            OPG_STORE:
            begin
                if (f3 inside {3'd0, 3'd1, 3'd2})
                begin
                    e.inv       = 1'b0;
                    e.mem_write = 1'b1;
                    e.op2_sel   = OP2_IMM;
                    e.imm       = imm_s;
                    e.imm_chk   = 1'b1;
                end
            end
            OPG_OP_IMM:
            begin
                // shift amounts share the funct7 field
                if ((f3 != 3'd1 && f3 != 3'd5) || f7 == F7_BASE || (f3 == 3'd5 && f7 == F7_ALT))
                begin
                    e.inv       = 1'b0;
                    e.reg_write = 1'b1;
                    e.op2_sel   = OP2_IMM;
                    e.alu       = alu_of(f3, f3 == 3'd5 && f7 == F7_ALT);
                    e.imm       = imm_i;
                    e.imm_chk   = 1'b1;
                end
            end
            OPG_OP:
            begin
                if (f7 == F7_BASE || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)))
                begin
                    e.inv       = 1'b0;
                    e.reg_write = 1'b1;
                    e.alu       = alu_of(f3, f7 == F7_ALT);
                end
            end
            OPG_BRANCH:
            begin
                if (f3 != 3'd2 && f3 != 3'd3)
                begin
                    e.inv     = 1'b0;
                    e.branch  = 1'b1;
                    e.alu     = cmp_of(f3);
                    e.imm     = imm_b;
                    e.imm_chk = 1'b1;
                end
            end
            OPG_JAL:
            begin
                e.inv       = 1'b0;
                e.reg_write = 1'b1;
                e.jump      = 1'b1;
                e.res_src   = RES_PC_P4;
                e.op1_sel   = OP1_PC;
                e.op2_sel   = OP2_IMM;
                e.imm       = imm_j;
                e.imm_chk   = 1'b1;
            end
            OPG_JALR:
            begin
                if (f3 == 3'd0)
                begin
                    e.inv       = 1'b0;
                    e.reg_write = 1'b1;
                    e.jump      = 1'b1;
                    e.pc_sel    = 1'b1;
                    e.res_src   = RES_PC_P4;
                    e.op2_sel   = OP2_IMM;
                    e.imm       = imm_i;
                    e.imm_chk   = 1'b1;
                end
            end
            OPG_LUI:
            begin
                e.inv       = 1'b0;
                e.reg_write = 1'b1;
                e.rs1       = '0;
                e.op2_sel   = OP2_IMM;
                e.imm       = imm_u;
                e.imm_chk   = 1'b1;
            end
            OPG_AUIPC:
            begin
                e.inv       = 1'b0;
                e.reg_write = 1'b1;
                e.op1_sel   = OP1_PC;
                e.op2_sel   = OP2_IMM;
                e.imm       = imm_u;
                e.imm_chk   = 1'b1;
            end
            OPG_MISC_MEM:
            begin
                if (f3 inside {3'd0, 3'd1})
                    e.inv = 1'b0;
            end
            default:
                e.inv = 1'b1;
        endcase
    end
    return e;
endfunction

`endif

// File: bench/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode import rv_decode_pkg::*;
();

`include "decode_model.svh"

    localparam int RST_CYCLES = 4;
    localparam int NUM_CYCLES = 2000;
    localparam int WAIT_LIMIT = 20;
    localparam int TIMEOUT_NS = 20 * (NUM_CYCLES + 200);

    logic                    i_clk;
    logic                    i_rst;
    logic                    i_stall;
    logic                    i_flush;
    logic [XLEN-1:0]         i_data;
    logic [XLEN-1:PC_LSB]    i_pc;
    logic [XLEN-1:PC_LSB]    i_pc_p4;
    logic [REG_IDX_W-1:0]    o_rs1;
    logic [REG_IDX_W-1:0]    o_rs2;
    logic [REG_IDX_W-1:0]    o_rd;
    logic [XLEN-1:PC_LSB]    o_pc;
    logic [XLEN-1:PC_LSB]    o_pc_p4;
    logic [XLEN-1:0]         o_imm;
    logic                    o_reg_write;
    logic                    o_mem_read;
    logic                    o_mem_write;
    logic [RES_SRC_W-1:0]    o_res_src;
    logic                    o_pc_sel;
    logic                    o_jump;
    logic                    o_branch;
    logic                    o_alu_op1_sel;
    logic                    o_alu_op2_sel;
    logic [FUNCT3_W-1:0]     o_funct3;
    logic [ALU_CTRL_W-1:0]   o_alu_ctrl;
    logic                    o_inv_instr;

    // model of the fetch hold state
    logic                    m_stall = 1'b0;
    logic                    m_flush = 1'b0;
    logic [XLEN-1:0]         m_held = '0;
    logic [XLEN-1:PC_LSB]    m_pc = '0;
    logic [XLEN-1:PC_LSB]    m_pc_p4 = '0;
    logic                    m_pc_ok = 1'b0;

    int checks = 0;
    int n_ctrl = 0;
    int n_field = 0;
    int n_alu = 0;
    int n_imm = 0;
    int n_pc = 0;

    rv_decode DUT (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            n_ctrl++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input logic [REG_IDX_W-1:0] got,
                             input logic [REG_IDX_W-1:0] exp);
        if (got !== exp)
        begin
            n_field++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_f3(input logic [FUNCT3_W-1:0] got, input logic [FUNCT3_W-1:0] exp);
        if (got !== exp)
        begin
            n_field++;
            $display("[ERROR] %0t: o_funct3 is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_res(input logic [RES_SRC_W-1:0] got, input logic [RES_SRC_W-1:0] exp);
        if (got !== exp)
        begin
            n_field++;
            $display("[ERROR] %0t: o_res_src is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_alu(input logic [ALU_CTRL_W-1:0] got, input logic [ALU_CTRL_W-1:0] exp,
                             input logic [XLEN-1:0] word);
        if (got !== exp)
        begin
            n_alu++;
            $display("[ERROR] %0t: o_alu_ctrl is %h, expected %h for word %h",
                     $time, got, exp, word);
        end
    endtask

    task automatic check_imm(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] word);
        if (got !== exp)
        begin
            n_imm++;
            $display("[ERROR] %0t: o_imm is %h, expected %h for word %h", $time, got, exp, word);
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:PC_LSB] got_pc, input logic [XLEN-1:PC_LSB] got_p4,
                            input logic [XLEN-1:PC_LSB] exp_pc, input logic [XLEN-1:PC_LSB] exp_p4);
        if (got_pc !== exp_pc || got_p4 !== exp_p4)
        begin
            n_pc++;
            $display("[ERROR] %0t: o_pc/o_pc_p4 are %h/%h, expected %h/%h",
                     $time, got_pc, got_p4, exp_pc, exp_p4);
        end
    endtask

    // random word of one instruction group or an illegal word for kind 11
    function automatic logic [XLEN-1:0] make_word(input int kind);
        logic [XLEN-1:0]     w;
        logic [FUNCT3_W-1:0] f3;
        w  = $urandom;
        f3 = w[14:12];
        case (kind)
            0:
            begin
                w[6:0] = {OPG_LOAD, 2'b11};
                if (f3 inside {3'd3, 3'd6, 3'd7})
                    w[14:12] = 3'd2;
            end
            1:
            begin
                w[6:0] = {OPG_STORE, 2'b11};
                w[14]  = 1'b0;
                if (w[13:12] == 2'b11)
                    w[13:12] = 2'b00;
            end
            2:
            begin
                w[6:0] = {OPG_OP_IMM, 2'b11};
                if (f3 == 3'd1)
                    w[31:25] = F7_BASE;
                else if (f3 == 3'd5)
                    w[31:25] = w[30] ? F7_ALT : F7_BASE;
            end
            3:
            begin
                w[6:0]   = {OPG_OP, 2'b11};
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? F7_ALT : F7_BASE;
            end
            4:
            begin
                w[6:0] = {OPG_BRANCH, 2'b11};
                if (f3 inside {3'd2, 3'd3})
                    w[13] = 1'b0;
            end
            5: w[6:0] = {OPG_JAL, 2'b11};
            6:
            begin
                w[6:0]   = {OPG_JALR, 2'b11};
                w[14:12] = 3'd0;
            end
            7: w[6:0] = {OPG_LUI, 2'b11};
            8: w[6:0] = {OPG_AUIPC, 2'b11};
            9:
            begin
                w[6:0]   = {OPG_MISC_MEM, 2'b11};
                w[14:13] = 2'b00;
            end
            10: w = '0;
            default:
            begin
                case ($urandom_range(0, 3))
                    0: w[1:0] = 2'b01;
                    1:
                    begin
                        w[6:0]   = {OPG_OP, 2'b11};
                        w[31:25] = 7'b0000001;
                    end
                    // ecall, then ebreak
                    2: w = 32'h0000_0073;
                    default: w = 32'h0010_0073;
                endcase
            end
        endcase
        return w;
    endfunction

    always @(posedge i_clk)
    begin
        logic [XLEN-1:0] word;
        decode_exp_t     e;
        if (i_rst || m_flush)
            word = '0;
        else if (m_stall)
            word = m_held;
        else
            word = i_data;
        e = decode_expect(word);
        check_ctrl("o_inv_instr", o_inv_instr, e.inv);
        if (!e.inv)
        begin
            check_ctrl("o_reg_write", o_reg_write, e.reg_write);
            check_ctrl("o_mem_read", o_mem_read, e.mem_read);
            check_ctrl("o_mem_write", o_mem_write, e.mem_write);
            check_ctrl("o_jump", o_jump, e.jump);
            check_ctrl("o_branch", o_branch, e.branch);
            check_ctrl("o_pc_sel", o_pc_sel, e.pc_sel);
            check_ctrl("o_alu_op1_sel", o_alu_op1_sel, e.op1_sel);
            check_ctrl("o_alu_op2_sel", o_alu_op2_sel, e.op2_sel);
            check_idx("o_rs1", o_rs1, e.rs1);
            check_idx("o_rs2", o_rs2, e.rs2);
            check_idx("o_rd", o_rd, e.rd);
            check_f3(o_funct3, e.funct3);
            check_res(o_res_src, e.res_src);
            check_alu(o_alu_ctrl, e.alu, word);
            if (e.imm_chk)
                check_imm(o_imm, e.imm, word);
        end
        if (m_pc_ok)
            check_pc(o_pc, o_pc_p4, m_pc, m_pc_p4);
        // state for the next cycle
        if (!m_stall)
            m_held = word;
        m_stall = i_rst ? 1'b0 : i_stall;
        m_flush = i_rst ? 1'b0 : i_flush;
        if (i_flush)
        begin
            m_pc    = '0;
            m_pc_p4 = '0;
        end
        else if (!i_stall)
        begin
            m_pc    = i_pc;
            m_pc_p4 = i_pc_p4;
        end
        m_pc_ok = 1'b1;
        checks++;
    end

    task automatic wait_checks(input int target, output logic ok);
        int waited;
        waited = 0;
        while (checks < target && waited < WAIT_LIMIT)
        begin
            @(negedge i_clk);
            waited++;
        end
        ok = (checks >= target);
    endtask

    initial
    begin
        logic [XLEN-1:0] pc_word;
        logic [XLEN-1:0] pc_next;
        logic            done;
        int              stall_left;
        int              total;
        i_rst      = 1'b1;
        i_stall    = 1'b0;
        i_flush    = 1'b0;
        i_data     = '0;
        i_pc       = '0;
        i_pc_p4    = '0;
        stall_left = 0;
        void'($urandom(32'hb26999f4));
        repeat (RST_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++)
        begin
            @(negedge i_clk);
            pc_word = $urandom;
            pc_next = pc_word + 32'd4;
            i_data  = make_word($urandom_range(0, 11));
            i_pc    = pc_word[XLEN-1:PC_LSB];
            i_pc_p4 = pc_next[XLEN-1:PC_LSB];
            i_flush = ($urandom_range(0, 15) == 0);
            // a second reset in the middle of the run
            i_rst   = (n >= 300 && n < 300 + RST_CYCLES);
            if (stall_left > 0)
            begin
                i_stall = 1'b1;
                stall_left--;
            end
            else
            begin
                i_stall = 1'b0;
                if ($urandom_range(0, 9) == 0)
                    stall_left = $urandom_range(1, 8);
            end
        end
        wait_checks(RST_CYCLES + NUM_CYCLES + 1, done);
        if (!done)
            $display("timeout: the compare process stopped after %0d cycles", checks);
        total = n_ctrl + n_field + n_alu + n_imm + n_pc;
        $display("errors: ctrl %0d, fields %0d, alu %0d, imm %0d, pc %0d over %0d cycles",
                 n_ctrl, n_field, n_alu, n_imm, n_pc, checks);
        if (done && total == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial
    begin
        #TIMEOUT_NS;
        $display("simulation time limit reached before the stimulus finished");
        $display("Something failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
logic/rv_decode_pkg.sv
logic/fetch_hold.sv
logic/instr_classify.sv
logic/imm_gen.sv
logic/operand_ctrl.sv
logic/rv_decode.sv
bench/tb_rv_decode.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rv_decode -f project.f -o sim_rv_decode
./obj_dir/sim_rv_decode > sim.log
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation FAILED"
    exit 1
fi
